// ==== ctmm_pkg.sv ====
`default_nettype none

package ctmm_pkg;

    // ========================================
    // Widths
    // ========================================
    localparam int CR_ADDR_W       = 4;   // CR0..CR15
    localparam int CLIST_INDEX_W   = 8;
    localparam int PRESERVE_MASK_W = 11;  // [10:5] CR0-5, [4:0] DR1-5
    localparam int REG_COUNT       = 16;  // Size of each register file

    // ========================================
    // Register roles and permission layout
    // ========================================
    localparam logic [CR_ADDR_W-1:0]     CR6_CLIST   = 4'd6;  // Phase 1 destination
    localparam logic [CR_ADDR_W-1:0]     CR7_NUCLEUS = 4'd7;  // Phase 2 destination
    localparam logic [CR_ADDR_W-1:0]     MAX_SRC_REG = 4'd5;  // Highest legal source
    localparam logic [CLIST_INDEX_W-1:0] OFFSET_ZERO = 8'd0;  // Entry 0 of the new C-List

    localparam int PERM_LSB = 48;  // Perm field base inside word0_gt
    localparam int PERM_W   = 10;
    localparam int PERM_L   = 2;   // Load permission

    // Full capability register, word0 first (MSBs)
    typedef struct packed {
        logic [63:0] word0_gt;    // Guard word, perms in [57:48]
        logic [63:0] word1_loc;
        logic [63:0] word2_lim;
        logic [63:0] word3_seal;
    } cap_reg_t;

    typedef enum logic [3:0] {
        FAULT_NONE   = 4'd0,
        FAULT_PERM   = 4'd1,
        FAULT_BOUNDS = 4'd2,
        FAULT_MAC    = 4'd3,
        FAULT_SEAL   = 4'd4
    } fault_type_t;

    typedef struct packed {
        logic [CR_ADDR_W-1:0]       cr_src;  // Source C-List register
        logic [CLIST_INDEX_W-1:0]   index;
        logic [PRESERVE_MASK_W-1:0] mask;    // 1 = preserve
    } call_req_t;

    // One capability load order for mLoad
    typedef struct packed {
        logic [CR_ADDR_W-1:0]     src;
        logic [CR_ADDR_W-1:0]     dst;
        logic [CLIST_INDEX_W-1:0] index;
    } mload_req_t;

    typedef struct packed {
        logic                 nia_set;   // Restart at offset zero
        logic [REG_COUNT-1:0] dr_clear;  // Bit i clears DR i
        logic [REG_COUNT-1:0] cr_clear;  // Bit i clears CR i
    } isolation_t;

endpackage

`default_nettype wire

// ==== ctmm_src_check.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctmm_src_check (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           accept,      // Request taken in idle
    input  logic [ctmm_pkg::CR_ADDR_W-1:0] cr_src_in,
    input  logic                           src_rd,      // Sequencer in read state
    input  ctmm_pkg::cap_reg_t             cr_rd_data,  // Same-cycle read data
    output logic                           cr_rd_en,
    output logic [ctmm_pkg::CR_ADDR_W-1:0] cr_rd_addr,
    output logic                           src_in_range,
    output logic                           src_has_l
);

    import ctmm_pkg::*;

    logic [CR_ADDR_W-1:0] cr_src_q;  // Source register number
    logic [PERM_W-1:0]    perm_q;    // Perm field of the source capability

    // ========================================
    // Source register number
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cr_src_q <= '0;
        end else if (accept) begin
            cr_src_q <= cr_src_in;
        end
    end

    // Only CR0..CR5 may name the C-List, CR6 is the load target
    assign src_in_range = (cr_src_q <= MAX_SRC_REG);

    // ========================================
    // Register read and permission test
    // ========================================
    assign cr_rd_en   = src_rd;
    assign cr_rd_addr = cr_src_q;  // Held stable for the whole call

    // Captured at the end of the read state
    always_ff @(posedge clk) begin
        if (src_rd) begin
            perm_q <= cr_rd_data.word0_gt[PERM_LSB +: PERM_W];
        end
    end

    // Valid the cycle after the read
    assign src_has_l = perm_q[PERM_L];

endmodule

`default_nettype wire

// ==== ctmm_call_seq.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctmm_call_seq (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  call_start,
    input  ctmm_pkg::call_req_t   call_req,
    input  logic                  src_in_range,
    input  logic                  src_has_l,
    input  logic                  mload_done,
    input  logic                  mload_fault,
    input  ctmm_pkg::fault_type_t mload_fault_type,
    output logic                  accept,       // One cycle, idle only
    output logic                  src_rd,
    output logic                  mload_start,
    output ctmm_pkg::mload_req_t  mload_req,
    output logic                  call_busy,
    output logic                  complete,
    output logic                  call_fault,
    output ctmm_pkg::fault_type_t fault_type
);

    import ctmm_pkg::*;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_CHECK_SRC,    // Range test on CRs
        ST_READ_SRC,     // Register port driven
        ST_CHECK_PERM,   // L bit test
        ST_PHASE1,       // mLoad CRs[Index] -> CR6
        ST_PHASE1_DONE,
        ST_PHASE2,       // mLoad CR6[0] -> CR7
        ST_COMPLETE,
        ST_FAULT
    } state_t;

    state_t state, next_state;

    logic [CR_ADDR_W-1:0]     cr_src_q;
    logic [CLIST_INDEX_W-1:0] index_q;
    logic                     phase;         // 0 loads CR6, 1 loads CR7
    logic                     start_d;       // Phase entry, one cycle ahead of the pulse
    logic                     start_q;
    logic                     done_seen;     // Sticky mLoad answers
    logic                     fault_seen;
    fault_type_t              mload_type_q;
    fault_type_t              fault_type_q;

    assign accept = (state == ST_IDLE) && call_start;
    assign src_rd = (state == ST_READ_SRC);

    // Request fields kept for the mLoad orders
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cr_src_q <= '0;
            index_q  <= '0;
        end else if (accept) begin
            cr_src_q <= call_req.cr_src;
            index_q  <= call_req.index;
        end
    end

    // ========================================
    // State machine
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE:        if (call_start) next_state = ST_CHECK_SRC;
            ST_CHECK_SRC:   next_state = src_in_range ? ST_READ_SRC : ST_FAULT;
            ST_READ_SRC:    next_state = ST_CHECK_PERM;
            ST_CHECK_PERM:  next_state = src_has_l ? ST_PHASE1 : ST_FAULT;
            ST_PHASE1: begin
                if (fault_seen) begin
                    next_state = ST_FAULT;
                end else if (done_seen) begin
                    next_state = ST_PHASE1_DONE;
                end
            end
            ST_PHASE1_DONE: next_state = ST_PHASE2;
            ST_PHASE2: begin
                if (fault_seen) begin
                    next_state = ST_FAULT;
                end else if (done_seen) begin
                    next_state = ST_COMPLETE;
                end
            end
            ST_COMPLETE,
            ST_FAULT:       next_state = ST_IDLE;
            default:        next_state = ST_IDLE;
        endcase
    end

    // ========================================
    // mLoad request generation
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= 1'b0;
        end else if (state == ST_IDLE) begin
            phase <= 1'b0;
        end else if (state == ST_PHASE1_DONE) begin
            phase <= 1'b1;  // Ready before the second start
        end
    end

    assign start_d = (state == ST_CHECK_PERM  && next_state == ST_PHASE1) ||
                     (state == ST_PHASE1_DONE && next_state == ST_PHASE2);

    // One pulse on entry to each phase
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_q <= 1'b0;
        end else begin
            start_q <= start_d;
        end
    end

    assign mload_start = start_q;

    always_comb begin
        if (phase) begin
            mload_req.src   = CR6_CLIST;    // CR6[0] -> CR7
            mload_req.dst   = CR7_NUCLEUS;
            mload_req.index = OFFSET_ZERO;
        end else begin
            mload_req.src   = cr_src_q;     // CRs[Index] -> CR6
            mload_req.dst   = CR6_CLIST;
            mload_req.index = index_q;
        end
    end

    // Answers held until the phase state looks at them
    // Cleared as the start is registered, so the phase sees only its own answer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_seen    <= 1'b0;
            fault_seen   <= 1'b0;
            mload_type_q <= FAULT_NONE;
        end else if (state == ST_IDLE || start_d) begin
            done_seen    <= 1'b0;
            fault_seen   <= 1'b0;
            mload_type_q <= FAULT_NONE;
        end else begin
            if (mload_done) done_seen <= 1'b1;
            if (mload_fault) begin
                fault_seen   <= 1'b1;
                mload_type_q <= mload_fault_type;  // Only valid with the pulse
            end
        end
    end

    // ========================================
    // Ending and fault reporting
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fault_type_q <= FAULT_NONE;
        end else if (next_state == ST_FAULT) begin
            // Own checks report PERM, mLoad keeps its own cause
            fault_type_q <= (state == ST_PHASE1 || state == ST_PHASE2) ?
                            mload_type_q : FAULT_PERM;
        end
    end

    assign call_busy  = (state != ST_IDLE);
    assign complete   = (state == ST_COMPLETE);
    assign call_fault = (state == ST_FAULT);  // Single cycle by construction
    assign fault_type = call_fault ? fault_type_q : FAULT_NONE;

endmodule

`default_nettype wire

// ==== ctmm_isolation.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctmm_isolation (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 accept,
    input  logic [ctmm_pkg::PRESERVE_MASK_W-1:0] mask_in,
    input  logic                                 complete,  // Successful CALL end
    output ctmm_pkg::isolation_t                 iso
);

    import ctmm_pkg::*;

    localparam int CR_KEEP_W = 6;  // CR0..CR5 in mask[10:5]
    localparam int DR_KEEP_W = 5;  // DR1..DR5 in mask[4:0]

    logic [PRESERVE_MASK_W-1:0] mask_q;
    logic [CR_KEEP_W-1:0]       cr_keep;
    logic [DR_KEEP_W-1:0]       dr_keep;
    logic [REG_COUNT-1:0]       dr_clear_full;
    logic [REG_COUNT-1:0]       cr_clear_full;

    // ========================================
    // Preserve mask
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mask_q <= '0;
        end else if (accept) begin
            mask_q <= mask_in;  // Held until the call ends
        end
    end

    assign cr_keep = mask_q[PRESERVE_MASK_W-1 -: CR_KEEP_W];
    assign dr_keep = mask_q[DR_KEEP_W-1:0];

    // DR0 argument survives, DR6 and up always wiped
    assign dr_clear_full = {{(REG_COUNT - DR_KEEP_W - 1){1'b1}}, ~dr_keep, 1'b0};

    // CR6 and up are never touched
    assign cr_clear_full = {{(REG_COUNT - CR_KEEP_W){1'b0}}, ~cr_keep};

    // ========================================
    // Isolation orders, one cycle at completion
    // ========================================
    always_comb begin
        iso          = '0;
        iso.nia_set  = complete;
        if (complete) begin
            iso.dr_clear = dr_clear_full;
            iso.cr_clear = cr_clear_full;
        end
    end

endmodule

`default_nettype wire

// ==== ctmm_call.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctmm_call (
    input  logic                           clk,
    input  logic                           rst_n,

    // CALL control
    input  logic                           call_start,        // One-cycle strobe
    input  ctmm_pkg::call_req_t            call_req,          // Sampled with call_start
    output logic                           call_busy,
    output logic                           call_complete,
    output logic                           call_fault,
    output ctmm_pkg::fault_type_t          fault_type,

    // Capability register read port
    output logic                           cr_rd_en,
    output logic [ctmm_pkg::CR_ADDR_W-1:0] cr_rd_addr,
    input  ctmm_pkg::cap_reg_t             cr_rd_data,        // Combinational reply

    // mLoad micro-routine
    output logic                           mload_start,
    output ctmm_pkg::mload_req_t           mload_req,
    input  logic                           mload_done,
    input  logic                           mload_fault,
    input  ctmm_pkg::fault_type_t          mload_fault_type,

    // Isolation orders
    output ctmm_pkg::isolation_t           iso
);

    logic accept;        // Request taken in idle
    logic src_rd;
    logic src_in_range;
    logic src_has_l;

    // ========================================
    // Sequencer
    // ========================================
    ctmm_call_seq u_seq (
        .clk              (clk),
        .rst_n            (rst_n),
        .call_start       (call_start),
        .call_req         (call_req),
        .src_in_range     (src_in_range),
        .src_has_l        (src_has_l),
        .mload_done       (mload_done),
        .mload_fault      (mload_fault),
        .mload_fault_type (mload_fault_type),
        .accept           (accept),
        .src_rd           (src_rd),
        .mload_start      (mload_start),
        .mload_req        (mload_req),
        .call_busy        (call_busy),
        .complete         (call_complete),
        .call_fault       (call_fault),
        .fault_type       (fault_type)
    );

    // Source register checks
    ctmm_src_check u_src (
        .clk          (clk),
        .rst_n        (rst_n),
        .accept       (accept),
        .cr_src_in    (call_req.cr_src),
        .src_rd       (src_rd),
        .cr_rd_data   (cr_rd_data),
        .cr_rd_en     (cr_rd_en),
        .cr_rd_addr   (cr_rd_addr),
        .src_in_range (src_in_range),
        .src_has_l    (src_has_l)
    );

    // Register clearing and restart
    ctmm_isolation u_iso (
        .clk      (clk),
        .rst_n    (rst_n),
        .accept   (accept),
        .mask_in  (call_req.mask),
        .complete (call_complete),
        .iso      (iso)
    );

endmodule

`default_nettype wire

// ==== tb_ctmm_call.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ctmm_call;

    import ctmm_pkg::*;

    localparam int CLK_PERIOD      = 10;
    localparam int NUM_CALLS       = 200;
    localparam int CYCLES_PER_CALL = 40;    // Per-call budget, also sizes the watchdog
    localparam int NO_END          = 1000;  // End cycle not yet known

    logic        clk;
    logic        rst_n;
    logic        call_start;
    call_req_t   call_req;
    cap_reg_t    cr_rd_data;
    logic        mload_done;
    logic        mload_fault;
    fault_type_t mload_fault_type;
    logic        call_busy;
    logic        call_complete;
    logic        call_fault;
    fault_type_t fault_type;
    logic        cr_rd_en;
    logic [CR_ADDR_W-1:0] cr_rd_addr;
    logic        mload_start;
    mload_req_t  mload_req;
    isolation_t  iso;

    int errors;
    int checks;
    int n_complete;
    int n_fault;

    ctmm_call dut (
        .clk (clk), .rst_n (rst_n),
        .call_start (call_start), .call_req (call_req),
        .call_busy (call_busy), .call_complete (call_complete),
        .call_fault (call_fault), .fault_type (fault_type),
        .cr_rd_en (cr_rd_en), .cr_rd_addr (cr_rd_addr), .cr_rd_data (cr_rd_data),
        .mload_start (mload_start), .mload_req (mload_req), .mload_done (mload_done),
        .mload_fault (mload_fault), .mload_fault_type (mload_fault_type),
        .iso (iso)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ========================================
    // Checking helpers
    // ========================================
    task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] got);
        begin
            checks++;
            assert (got === exp) else begin
                errors++;
                $display("[ERROR] %0t ns %s expected %0h actual %0h", $time, name, exp, got);
            end
        end
    endtask

    // Clear masks from the preserve rule, DR1 <- mask[0], CR0 <- mask[5]
    function automatic isolation_t iso_expect(input logic [PRESERVE_MASK_W-1:0] mask);
        isolation_t e;
        begin
            e.nia_set  = 1'b1;
            e.dr_clear = {10'h3FF, ~mask[4:0], 1'b0};  // DR0 kept, DR6 and up wiped
            e.cr_clear = {10'h000, ~mask[10:5]};       // CR6 and up untouched
            return e;
        end
    endfunction

    task automatic idle_cycle;
        begin
            @(posedge clk);
            call_start       <= 1'b0;
            mload_done       <= 1'b0;
            mload_fault      <= 1'b0;
            mload_fault_type <= FAULT_NONE;
            @(negedge clk);
            check_val("call_busy", 64'd0, 64'(call_busy));
            check_val("call_complete", 64'd0, 64'(call_complete));
            check_val("call_fault", 64'd0, 64'(call_fault));
            check_val("mload_start", 64'd0, 64'(mload_start));
            check_val("iso", 64'd0, 64'(iso));
        end
    endtask

    // ========================================
    // One CALL with mLoad responder and reference model
    // ========================================
    task automatic run_call(input int num);
        call_req_t   req;
        cap_reg_t    cap;
        logic [31:0] r;
        mload_req_t  exp_req;
        isolation_t  iso_exp;
        fault_type_t end_type;
        fault_type_t ans_type;
        logic        range_ok;
        logic        l_ok;
        logic        end_fault;
        logic        ans_fault;
        logic        exp_start;
        logic        exp_end;
        int          c;
        int          start_cyc;
        int          end_cyc;
        int          ans_cyc;
        int          n_starts;
        bit          finished;
        begin
            r   = $urandom;
            req = r[22:0];
            cap = {$urandom, $urandom, $urandom, $urandom,
                   $urandom, $urandom, $urandom, $urandom};
            cap.word0_gt[PERM_LSB + PERM_L] = r[23];  // Random L permission
            range_ok = (req.cr_src <= MAX_SRC_REG);
            l_ok     = r[23];
            // Cycle 0 is the accept cycle
            start_cyc = NO_END;
            end_cyc   = NO_END;
            ans_cyc   = -1;
            n_starts  = 0;
            ans_fault = 1'b0;
            ans_type  = FAULT_NONE;
            end_fault = 1'b1;
            end_type  = FAULT_PERM;
            exp_req.src   = req.cr_src;  // CRs[Index] -> CR6
            exp_req.dst   = 4'd6;
            exp_req.index = req.index;
            if (!range_ok) begin
                end_cyc = 2;
            end else if (!l_ok) begin
                end_cyc = 4;
            end else begin
                start_cyc = 4;
            end
            @(posedge clk);
            call_start <= 1'b1;
            call_req   <= req;
            cr_rd_data <= cap;
            c        = 0;
            finished = 0;
            while (!finished) begin
                @(negedge clk);
                exp_start = (c == start_cyc);
                exp_end   = (c == end_cyc);
                check_val("call_busy", 64'(c != 0), 64'(call_busy));
                check_val("cr_rd_en", 64'((c == 2) && range_ok), 64'(cr_rd_en));
                if (cr_rd_en) check_val("cr_rd_addr", 64'(req.cr_src), 64'(cr_rd_addr));
                check_val("mload_start", 64'(exp_start), 64'(mload_start));
                if (mload_start && exp_start) begin
                    check_val("mload_req", 64'(exp_req), 64'(mload_req));
                    n_starts++;
                    r         = $urandom;
                    ans_cyc   = c + 1 + int'(r[2:0]);      // 1 to 8 cycles later
                    ans_fault = ((r[15:8] % 6) == 0);      // About one in six
                    ans_type  = fault_type_t'(4'd1 + {2'b00, r[17:16]});
                    if (ans_fault) begin
                        end_cyc  = ans_cyc + 2;
                        end_type = ans_type;
                    end else if (n_starts == 1) begin
                        start_cyc     = ans_cyc + 3;
                        exp_req.src   = 4'd6;  // CR6[0] -> CR7
                        exp_req.dst   = 4'd7;
                        exp_req.index = 8'd0;
                    end else begin
                        end_cyc   = ans_cyc + 2;
                        end_fault = 1'b0;
                    end
                end
                iso_exp = '0;
                if (exp_end && !end_fault) iso_exp = iso_expect(req.mask);
                check_val("call_complete", 64'(exp_end && !end_fault), 64'(call_complete));
                check_val("call_fault", 64'(exp_end && end_fault), 64'(call_fault));
                check_val("fault_type", 64'((exp_end && end_fault) ? end_type : FAULT_NONE),
                          64'(fault_type));
                check_val("iso", 64'(iso_exp), 64'(iso));
                if (exp_end) begin
                    finished = 1;
                end else if (c >= CYCLES_PER_CALL) begin
                    errors++;
                    $display("Call %0d did not end within %0d cycles", num, CYCLES_PER_CALL);
                    finished = 1;
                end else begin
                    @(posedge clk);
                    r = $urandom;
                    call_start       <= (r[1:0] == 2'b00);  // Stray strobe while busy
                    call_req         <= r[31:9];
                    mload_done       <= (c + 1 == ans_cyc) && !ans_fault;
                    mload_fault      <= (c + 1 == ans_cyc) && ans_fault;
                    mload_fault_type <= ((c + 1 == ans_cyc) && ans_fault) ? ans_type : FAULT_NONE;
                    c++;
                end
            end
            if (end_fault) n_fault++;
            else n_complete++;
        end
    endtask

    // ========================================
    // Main sequence
    // ========================================
    initial begin
        int i;
        clk              = 1'b0;
        rst_n            = 1'b0;
        call_start       = 1'b0;
        call_req         = '0;
        cr_rd_data       = '0;
        mload_done       = 1'b0;
        mload_fault      = 1'b0;
        mload_fault_type = FAULT_NONE;
        errors     = 0;
        checks     = 0;
        n_complete = 0;
        n_fault    = 0;
        void'($urandom(32'h50911cfb));
        repeat (2) @(posedge clk);
        @(negedge clk);
        // Outputs quiet in reset
        check_val("call_busy", 64'd0, 64'(call_busy));
        check_val("call_complete", 64'd0, 64'(call_complete));
        check_val("call_fault", 64'd0, 64'(call_fault));
        check_val("mload_start", 64'd0, 64'(mload_start));
        check_val("cr_rd_en", 64'd0, 64'(cr_rd_en));
        check_val("iso", 64'd0, 64'(iso));
        check_val("fault_type", 64'(FAULT_NONE), 64'(fault_type));
        @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) idle_cycle();
        for (i = 0; i < NUM_CALLS; i++) begin
            run_call(i);
            repeat ($urandom % 3) idle_cycle();
        end
        idle_cycle();
        $display("Summary: %0d calls, %0d completed, %0d faulted, %0d checks, %0d errors",
                 NUM_CALLS, n_complete, n_fault, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // Watchdog sized from the call count
    initial begin
        #(NUM_CALLS * CYCLES_PER_CALL * CLK_PERIOD);
        $display("Timeout: run did not finish after %0d calls worth of cycles", NUM_CALLS);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
ctmm_pkg.sv
ctmm_src_check.sv
ctmm_call_seq.sv
ctmm_isolation.sv
ctmm_call.sv
tb_ctmm_call.sv

// ==== Makefile ====
TOP := tb_ctmm_call

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -o sim
	@out=$$(./obj_dir/sim); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

lint:
	verilator --lint-only --timing -Wall -f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir
